//--- logic/aesDataPkg.sv
`default_nettype none

package aesDataPkg;

        localparam int ByteWidth = 8;
        localparam int WordWidth = 32;
        localparam int BlockWidth = 128;
        localparam int BlockWords = BlockWidth / WordWidth;
        localparam int BlockBytes = BlockWidth / ByteWidth;

        // GF(2^8) element
        typedef logic [ByteWidth-1:0] aesByte;
        // First byte in the top bits
        typedef logic [WordWidth-1:0] aesWord;
        // Column 0 in the top word
        typedef logic [BlockWidth-1:0] aesBlock;

        ////////////////////////////////////////
        // Forward S-box
        ////////////////////////////////////////
        localparam aesByte SBOX [256] = '{
                8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
                8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
                8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
                8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
                8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
                8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
                8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
                8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
                8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
                8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
                8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
                8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
                8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
                8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
                8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
                8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
                8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
                8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
                8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
                8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
                8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
                8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
                8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
                8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
                8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
                8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
                8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
                8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
                8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
                8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
                8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
                8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
        };

endpackage

`default_nettype wire

//--- logic/aesCtrlPkg.sv
`default_nettype none

package aesCtrlPkg;

        localparam int RoundIdxWidth = 4;
        // Enough for the 60 words of an AES-256 schedule
        localparam int KeyAddrWidth = 6;

        typedef logic [RoundIdxWidth-1:0] roundIndex;
        typedef logic [KeyAddrWidth-1:0] keyIndex;

        typedef enum logic [2:0] {
                LoadKey,
                WaitBlock,
                InitialRound,
                Rounds,
                Finish
        } ctrlState;

        // Datapath command, valid for the current cycle
        typedef struct packed {
                logic       loadWord;
                logic [1:0] loadSlot;
                logic       addInitial;
                logic       doRound;
                logic       lastRound;
        } blockCmd;

endpackage

`default_nettype wire

//--- logic/aesControl.sv
`default_nettype none

module aesControl #(
        parameter int NumRounds = 14
) (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  expandedKeyEnable,
        input  logic                  plaintextEnable,
        output logic                  keyWrite,
        output aesCtrlPkg::keyIndex   keyAddr,
        output aesCtrlPkg::roundIndex roundIdx,
        output aesCtrlPkg::blockCmd   cmd,
        output logic                  ciphertextDone
);
        import aesDataPkg::*;
        import aesCtrlPkg::*;

        localparam int KeyWords = BlockWords * (NumRounds + 1);

        ctrlState  curState;
        keyIndex   keyCount;
        logic [1:0] wordCount;
        roundIndex roundCount;
        logic      wordAccept;

        // Next block may start while the done pulse is up
        assign wordAccept = plaintextEnable && (curState == WaitBlock || curState == Finish);

        assign keyWrite = expandedKeyEnable && (curState == LoadKey);
        assign keyAddr = keyCount;
        assign roundIdx = roundCount;
        assign ciphertextDone = (curState == Finish);

        always_comb begin
                cmd = '0;
                cmd.loadWord = wordAccept;
                cmd.loadSlot = wordCount;
                cmd.addInitial = (curState == InitialRound);
                cmd.doRound = (curState == Rounds);
                cmd.lastRound = (curState == Rounds) && (roundCount == roundIndex'(NumRounds));
        end

        ////////////////////////////////////////
        // Sequencer
        ////////////////////////////////////////
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        curState <= LoadKey;
                        keyCount <= '0;
                        wordCount <= '0;
                        roundCount <= '0;
                end else begin
                        case (curState)
                        LoadKey: begin
                                if (keyWrite) begin
                                        keyCount <= keyCount + 1'b1;
                                        if (keyCount == keyIndex'(KeyWords - 1))
                                                curState <= WaitBlock;
                                end
                        end
                        WaitBlock, Finish: begin
                                if (wordAccept)
                                        wordCount <= wordCount + 1'b1;
                                if (wordAccept && wordCount == 2'(BlockWords - 1))
                                        curState <= InitialRound;
                                else
                                        curState <= WaitBlock;
                        end
                        InitialRound: begin
                                roundCount <= roundCount + 1'b1;
                                curState <= Rounds;
                        end
                        Rounds: begin
                                if (roundCount == roundIndex'(NumRounds)) begin
                                        roundCount <= '0;
                                        curState <= Finish;
                                end else begin
                                        roundCount <= roundCount + 1'b1;
                                end
                        end
                        default: curState <= LoadKey;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- logic/roundKeyStore.sv
`default_nettype none

module roundKeyStore #(
        parameter int NumRounds = 14
) (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  keyWrite,
        input  aesCtrlPkg::keyIndex   keyAddr,
        input  aesDataPkg::aesWord    expandedKey,
        input  aesCtrlPkg::roundIndex roundIdx,
        output aesDataPkg::aesBlock   roundKey
);
        import aesDataPkg::*;

        localparam int KeyWords = BlockWords * (NumRounds + 1);

        aesWord keyWords [KeyWords];

        // Schedule words in arrival order
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        for (int i = 0; i < KeyWords; i++) begin
                                keyWords[i] <= '0;
                        end
                end else if (keyWrite) begin
                        keyWords[keyAddr] <= expandedKey;
                end
        end

        // Round r uses words 4r .. 4r+3, first word on top
        always_comb begin
                for (int i = 0; i < BlockWords; i++) begin
                        roundKey[(BlockWords - 1 - i) * WordWidth +: WordWidth] =
                                keyWords[{roundIdx, 2'(i)}];
                end
        end

endmodule

`default_nettype wire

//--- logic/blockState.sv
`default_nettype none

module blockState (
        input  logic                clk,
        input  logic                rst,
        input  aesCtrlPkg::blockCmd cmd,
        input  aesDataPkg::aesWord  plaintext,
        input  aesDataPkg::aesBlock roundKey,
        input  aesDataPkg::aesBlock roundOut,
        output aesDataPkg::aesBlock state
);
        import aesDataPkg::*;

        aesBlock staging;

        // Plaintext collects here so the state keeps the last ciphertext
        always_ff @(posedge clk) begin
                if (cmd.loadWord) begin
                        staging[(BlockWords - 1 - cmd.loadSlot) * WordWidth +: WordWidth] <=
                                plaintext;
                end
        end

        ////////////////////////////////////////
        // State register with AddRoundKey
        ////////////////////////////////////////
        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        state <= '0;
                end else if (cmd.addInitial) begin
                        state <= staging ^ roundKey;
                end else if (cmd.doRound) begin
                        state <= roundOut ^ roundKey;
                end
        end

endmodule

`default_nettype wire

//--- logic/roundFunction.sv
`default_nettype none

module roundFunction (
        input  aesDataPkg::aesBlock state,
        input  logic                lastRound,
        output aesDataPkg::aesBlock roundOut
);
        import aesDataPkg::*;

        // Multiply by 2 in GF(2^8)
        function automatic aesByte xtime(aesByte b);
                return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        endfunction

        aesByte subBytes [BlockBytes];
        aesByte shifted [BlockBytes];

        // Byte k sits in row k%4 of column k/4
        always_comb begin
                for (int k = 0; k < BlockBytes; k++) begin
                        subBytes[k] = SBOX[state[BlockWidth - 1 - ByteWidth * k -: ByteWidth]];
                end
        end

        // Row r rotated left by r columns
        always_comb begin
                for (int c = 0; c < BlockWords; c++) begin
                        for (int r = 0; r < BlockWords; r++) begin
                                shifted[BlockWords * c + r] =
                                        subBytes[BlockWords * ((c + r) % BlockWords) + r];
                        end
                end
        end

        ////////////////////////////////////////
        // MixColumns
        ////////////////////////////////////////
        always_comb begin
                aesByte col [4];
                aesByte mixed [4];
                for (int c = 0; c < BlockWords; c++) begin
                        for (int r = 0; r < BlockWords; r++) begin
                                col[r] = shifted[BlockWords * c + r];
                        end
                        mixed[0] = xtime(col[0]) ^ xtime(col[1]) ^ col[1] ^ col[2] ^ col[3];
                        mixed[1] = col[0] ^ xtime(col[1]) ^ xtime(col[2]) ^ col[2] ^ col[3];
                        mixed[2] = col[0] ^ col[1] ^ xtime(col[2]) ^ xtime(col[3]) ^ col[3];
                        mixed[3] = xtime(col[0]) ^ col[0] ^ col[1] ^ col[2] ^ xtime(col[3]);
                        // Final round keeps the shifted column
                        if (lastRound) begin
                                mixed = col;
                        end
                        roundOut[BlockWidth - 1 - WordWidth * c -: WordWidth] =
                                {mixed[0], mixed[1], mixed[2], mixed[3]};
                end
        end

endmodule

`default_nettype wire

//--- logic/aesEncryptTop.sv
`default_nettype none

module aesEncryptTop #(
        parameter int NumRounds = 14
) (
        input  logic                clk,
        input  logic                rst,
        input  logic                expandedKeyEnable,
        input  aesDataPkg::aesWord  expandedKey,
        input  logic                plaintextEnable,
        input  aesDataPkg::aesWord  plaintext,
        output logic                ciphertextDone,
        output aesDataPkg::aesBlock ciphertext
);
        import aesDataPkg::*;
        import aesCtrlPkg::*;

        blockCmd   cmd;
        logic      keyWrite;
        keyIndex   keyAddr;
        roundIndex roundIdx;
        aesBlock   roundKey;
        aesBlock   roundOut;

        aesControl #(.NumRounds(NumRounds)) controlUnit (
                .clk(clk),
                .rst(rst),
                .expandedKeyEnable(expandedKeyEnable),
                .plaintextEnable(plaintextEnable),
                .keyWrite(keyWrite),
                .keyAddr(keyAddr),
                .roundIdx(roundIdx),
                .cmd(cmd),
                .ciphertextDone(ciphertextDone)
        );

        roundKeyStore #(.NumRounds(NumRounds)) keyStore (
                .clk(clk),
                .rst(rst),
                .keyWrite(keyWrite),
                .keyAddr(keyAddr),
                .expandedKey(expandedKey),
                .roundIdx(roundIdx),
                .roundKey(roundKey)
        );

        // State register doubles as the ciphertext output
        blockState stateReg (
                .clk(clk),
                .rst(rst),
                .cmd(cmd),
                .plaintext(plaintext),
                .roundKey(roundKey),
                .roundOut(roundOut),
                .state(ciphertext)
        );

        roundFunction roundLogic (
                .state(ciphertext),
                .lastRound(cmd.lastRound),
                .roundOut(roundOut)
        );

endmodule

`default_nettype wire

//--- verif/aesChecker.sv
`default_nettype none

module aesChecker #(
        parameter int NumRounds = 10
) (
        input  logic                clk,
        input  logic                rst,
        input  logic                expandedKeyEnable,
        input  aesDataPkg::aesWord  expandedKey,
        input  logic                plaintextEnable,
        input  aesDataPkg::aesWord  plaintext,
        input  logic                ciphertextDone,
        input  aesDataPkg::aesBlock ciphertext,
        output int                  valueErrors,
        output int                  timingErrors
);
        timeunit 1ns;
        timeprecision 100ps;

        import aesDataPkg::*;

        localparam int KeyWords = BlockWords * (NumRounds + 1);
        localparam aesBlock KnownCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

        aesWord  keyMem [KeyWords];
        aesBlock ptBuf;
        aesBlock expected;
        aesBlock lastResult = '0;
        int      keyCount = 0;
        int      wordCount = 0;
        int      blockNum = 0;
        int      cycle = 0;
        int      takeCycle = 0;
        bit      busy = 1'b0;
        bit      doneDue;

        initial begin
                valueErrors = 0;
                timingErrors = 0;
        end

        ////////////////////////////////////////
        // Reference AES
        ////////////////////////////////////////
        function automatic aesByte gfMul(aesByte a, aesByte b);
                aesByte p = 8'h00;
                for (int i = 0; i < 8; i++) begin
                        p ^= b[i] ? a : 8'h00;
                        a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
                end
                return p;
        endfunction

        // Inverse as x^254 followed by the affine map
        function automatic aesByte sboxRef(aesByte x);
                aesByte v = 8'h01;
                repeat (254) v = gfMul(v, x);
                return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]}
                       ^ {v[3:0], v[7:4]} ^ 8'h63;
        endfunction

        // Byte i is row i%4 of column i/4
        function automatic aesBlock encryptRef(aesBlock pt);
                aesByte  s [16];
                aesByte  t [16];
                aesBlock out;
                int      j;
                for (int i = 0; i < 16; i++)
                        s[i] = pt[127 - 8 * i -: 8] ^ keyMem[i / 4][31 - 8 * (i % 4) -: 8];
                for (int rnd = 1; rnd <= NumRounds; rnd++) begin
                        for (int i = 0; i < 16; i++)
                                t[i] = sboxRef(s[(i + 4 * (i % 4)) % 16]);
                        for (int i = 0; i < 16; i++) begin
                                j = i - i % 4;
                                s[i] = t[i];
                                if (rnd < NumRounds)
                                        s[i] = gfMul(t[i], 8'h02)
                                               ^ gfMul(t[j + (i + 1) % 4], 8'h03)
                                               ^ t[j + (i + 2) % 4] ^ t[j + (i + 3) % 4];
                                s[i] ^= keyMem[4 * rnd + i / 4][31 - 8 * (i % 4) -: 8];
                        end
                end
                for (int i = 0; i < 16; i++)
                        out[127 - 8 * i -: 8] = s[i];
                return out;
        endfunction

        task automatic compareBlock(input string name, input aesBlock exp, input aesBlock act);
                if (exp !== act) begin
                        valueErrors++;
                        $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
                end
        endtask

        always @(posedge clk or negedge rst) begin
                if (!rst) begin
                        keyCount = 0;
                        wordCount = 0;
                        busy = 1'b0;
                        lastResult = '0;
                end else begin
                        cycle++;
                        doneDue = busy && cycle == takeCycle + NumRounds + 2;
                        if (ciphertextDone !== doneDue) begin
                                timingErrors++;
                                $display("CHECK FAILED done timing: expected %b, actual %b at cycle %0d",
                                         doneDue, ciphertextDone, cycle);
                        end
                        // Held from the done pulse until the next initial round
                        if ((!busy || cycle <= takeCycle + 1) && ciphertext !== lastResult)
                                compareBlock("output hold", lastResult, ciphertext);
                        if (doneDue) begin
                                compareBlock($sformatf("block %0d", blockNum), expected, ciphertext);
                                if (blockNum == 0)
                                        compareBlock("known vector", KnownCipher, ciphertext);
                                lastResult = expected;
                                blockNum++;
                                busy = 1'b0;
                        end
                        // Words the DUT should take on this edge
                        if (expandedKeyEnable && keyCount < KeyWords) begin
                                keyMem[keyCount] = expandedKey;
                                keyCount++;
                        end else if (plaintextEnable && keyCount == KeyWords && !busy) begin
                                ptBuf[127 - 32 * wordCount -: 32] = plaintext;
                                wordCount++;
                                if (wordCount == BlockWords) begin
                                        wordCount = 0;
                                        busy = 1'b1;
                                        takeCycle = cycle;
                                        expected = encryptRef(ptBuf);
                                end
                        end
                end
        end

endmodule

`default_nettype wire

//--- verif/aesTb.sv
`default_nettype none

module aesTb;
        timeunit 1ns;
        timeprecision 100ps;

        import aesDataPkg::*;

        localparam int NumRounds = 10;
        localparam int KeyWords = BlockWords * (NumRounds + 1);

        logic        clk = 1'b0;
        logic        rst;
        logic        expandedKeyEnable;
        logic        plaintextEnable;
        logic        ciphertextDone;
        aesWord      expandedKey;
        aesWord      plaintext;
        aesBlock     ciphertext;
        int          valueErrors;
        int          timingErrors;
        int          timeouts = 0;
        logic [31:0] lfsr = 32'h9b53;

        aesEncryptTop #(.NumRounds(NumRounds)) dut_i (.*);
        aesChecker #(.NumRounds(NumRounds)) scoreboard_i (.*);

        always #2 clk = ~clk;

        // Galois LFSR stepped once per bit
        function automatic logic [31:0] randBits(int n);
                logic [31:0] r = '0;
                for (int i = 0; i < n; i++) begin
                        r = {r[30:0], lfsr[0]};
                        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
                end
                return r;
        endfunction

        task automatic resetDut();
                rst = 1'b0;
                expandedKeyEnable = 1'b0;
                plaintextEnable = 1'b0;
                repeat (4) @(negedge clk);
                rst = 1'b1;
        endtask

        ////////////////////////////////////////
        // Stimulus
        ////////////////////////////////////////
        // AES-128 key expansion with each word strobed as soon as it is known
        task automatic loadKey(input aesBlock key);
                aesWord w [KeyWords];
                aesWord t;
                aesByte rcon = 8'h01;
                for (int i = 0; i < KeyWords; i++) begin
                        if (i < 4) begin
                                w[i] = key[127 - 32 * i -: 32];
                        end else begin
                                t = w[i - 1];
                                if (i % 4 == 0) begin
                                        t = {SBOX[t[23:16]], SBOX[t[15:8]],
                                             SBOX[t[7:0]], SBOX[t[31:24]]} ^ {rcon, 24'h0};
                                        rcon = {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
                                end
                                w[i] = w[i - 4] ^ t;
                        end
                        expandedKey = w[i];
                        expandedKeyEnable = 1'b1;
                        // Early plaintext strobes
                        plaintextEnable = randBits(1) != 0;
                        plaintext = randBits(32);
                        @(negedge clk);
                end
                expandedKeyEnable = 1'b0;
                plaintextEnable = 1'b0;
        endtask

        task automatic runBlock(input aesBlock blk, input bit gaps, input bit extra);
                int n = 0;
                for (int i = 0; i < BlockWords; i++) begin
                        plaintext = blk[127 - 32 * i -: 32];
                        plaintextEnable = 1'b1;
                        @(negedge clk);
                        plaintextEnable = 1'b0;
                        if (gaps && i < BlockWords - 1)
                                repeat (randBits(2)) @(negedge clk);
                end
                // These arrive during the rounds
                plaintextEnable = extra;
                repeat (extra ? 3 : 0) begin
                        plaintext = randBits(32);
                        @(negedge clk);
                end
                plaintextEnable = 1'b0;
                while (ciphertextDone !== 1'b1 && n < 40) begin
                        @(negedge clk);
                        n++;
                end
                if (ciphertextDone !== 1'b1) begin
                        timeouts++;
                        $display("Timed out waiting for ciphertextDone");
                end
                if (gaps)
                        repeat (randBits(2)) @(negedge clk);
        endtask

        initial begin
                expandedKey = '0;
                plaintext = '0;
                resetDut();
                loadKey(128'h000102030405060708090a0b0c0d0e0f);
                runBlock(128'h00112233445566778899aabbccddeeff, 1'b0, 1'b0);
                // Done pulse is sampled on the next rising edge
                @(negedge clk);
                // The schedule is write-once, so a new key needs a reset
                resetDut();
                loadKey({randBits(32), randBits(32), randBits(32), randBits(32)});
                for (int b = 0; b < 8; b++)
                        runBlock({randBits(32), randBits(32), randBits(32), randBits(32)},
                                 b >= 4, b == 2 || b == 5);
                repeat (4) @(negedge clk);
                $display("Error counts: %0d value, %0d timing, %0d timeouts",
                         valueErrors, timingErrors, timeouts);
                if (valueErrors + timingErrors + timeouts == 0)
                        $display("TEST RESULT: PASS");
                else
                        $display("TEST RESULT: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- sources.f
logic/aesDataPkg.sv
logic/aesCtrlPkg.sv
logic/aesControl.sv
logic/roundKeyStore.sv
logic/blockState.sv
logic/roundFunction.sv
logic/aesEncryptTop.sv
verif/aesChecker.sv
verif/aesTb.sv
